// File: hw/core_cfg.svh
// core sizing constants
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define CORE_XLEN 32
// architectural integer registers
`define CORE_NREGS 32
// data RAM depth in words
`define CORE_DMEM_WORDS 64

`endif

// File: hw/core_pkg.sv
// execute pipeline types
`default_nettype none
`include "core_cfg.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] xlen_t;
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_beq  = 3'd1,
    br_bne  = 3'd2,
    br_blt  = 3'd3,
    br_bge  = 3'd4,
    br_jal  = 3'd5,
    br_jalr = 3'd6
  } br_op_e;

  typedef enum logic [1:0] {
    mem_none  = 2'd0,
    mem_load  = 2'd1,
    mem_store = 2'd2
  } mem_op_e;

  // decoded op as issued by the front end
  typedef struct packed {
    xlen_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     use_rs1;
    logic     use_rs2;
    xlen_t    imm;
    logic     use_imm;
    alu_op_e  alu_op;
    br_op_e   br_op;
    mem_op_e  mem_op;
    logic     wr_ena;
  } ex_uop_t;

  typedef struct packed {
    xlen_t    result;
    xlen_t    store_data;
    reg_idx_t rd;
    mem_op_e  mem_op;
    logic     wr_ena;
  } mem_uop_t;

  typedef struct packed {
    xlen_t    value;
    reg_idx_t rd;
    logic     wr_ena;
    logic     is_load;
  } wb_uop_t;

endpackage

`default_nettype wire

// File: hw/pipe_reg.sv
// valid/allowin stage register
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  input  logic     next_allowin,
  input  logic     ready_go,
  output logic     allowin,
  output logic     out_valid,
  output payload_t out_data
);

  logic     valid_q;
  payload_t data_q;

  // accept when empty or when the held op moves on this cycle
  assign allowin   = !valid_q || (ready_go && next_allowin);
  assign out_valid = valid_q && ready_go;
  assign out_data  = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (allowin) begin
      valid_q <= in_valid;
    end
    if (in_valid && allowin) begin
      data_q <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/forward_unit.sv
// operand bypass and load-use detection
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
  input  core_pkg::reg_idx_t rs1,
  input  core_pkg::reg_idx_t rs2,
  input  logic               use_rs1,
  input  logic               use_rs2,
  input  core_pkg::xlen_t    rf_rs1_data,
  input  core_pkg::xlen_t    rf_rs2_data,
  input  logic               mem_valid,
  input  core_pkg::reg_idx_t mem_rd,
  input  logic               mem_wr_ena,
  input  logic               mem_is_load,
  input  core_pkg::xlen_t    mem_value,
  input  logic               wb_valid,
  input  core_pkg::reg_idx_t wb_rd,
  input  logic               wb_wr_ena,
  input  core_pkg::xlen_t    wb_value,
  output core_pkg::xlen_t    rs1_value,
  output core_pkg::xlen_t    rs2_value,
  output logic               hazard
);

  import core_pkg::*;

  logic mem_hit1;
  logic mem_hit2;
  logic wb_hit1;
  logic wb_hit2;

  // x0 never forwards
  assign mem_hit1 = mem_valid && mem_wr_ena && (mem_rd != '0) && (mem_rd == rs1);
  assign mem_hit2 = mem_valid && mem_wr_ena && (mem_rd != '0) && (mem_rd == rs2);
  assign wb_hit1  = wb_valid && wb_wr_ena && (wb_rd != '0) && (wb_rd == rs1);
  assign wb_hit2  = wb_valid && wb_wr_ena && (wb_rd != '0) && (wb_rd == rs2);

  // newer op in memory wins over writeback
  assign rs1_value = mem_hit1 ? mem_value : (wb_hit1 ? wb_value : rf_rs1_data);
  assign rs2_value = mem_hit2 ? mem_value : (wb_hit2 ? wb_value : rf_rs2_data);

  // load data only exists once the op reaches writeback
  assign hazard = mem_is_load && ((use_rs1 && mem_hit1) || (use_rs2 && mem_hit2));

endmodule

`default_nettype wire

// File: hw/alu.sv
// integer ALU and branch compare
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  core_pkg::xlen_t   op1,
  input  core_pkg::xlen_t   op2,
  input  core_pkg::alu_op_e alu_op,
  input  core_pkg::br_op_e  br_op,
  output core_pkg::xlen_t   result,
  output logic              br_cond
);

  import core_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt;

  assign shamt = op2[4:0];
  assign eq    = (op1 == op2);
  assign lt    = ($signed(op1) < $signed(op2));

  always_comb begin
    case (alu_op)
      alu_sub:  result = op1 - op2;
      alu_and:  result = op1 & op2;
      alu_or:   result = op1 | op2;
      alu_xor:  result = op1 ^ op2;
      alu_sll:  result = op1 << shamt;
      alu_srl:  result = op1 >> shamt;
      alu_sra:  result = xlen_t'($signed(op1) >>> shamt);
      alu_slt:  result = xlen_t'(lt);
      alu_sltu: result = xlen_t'(op1 < op2);
      default:  result = op1 + op2;
    endcase
  end

  // jumps are always taken
  always_comb begin
    case (br_op)
      br_beq:           br_cond = eq;
      br_bne:           br_cond = !eq;
      br_blt:           br_cond = lt;
      br_bge:           br_cond = !lt;
      br_jal, br_jalr:  br_cond = 1'b1;
      default:          br_cond = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/ex_stage.sv
// execute stage
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module ex_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  core_pkg::ex_uop_t   in_uop,
  output logic                in_allowin,
  output core_pkg::reg_idx_t  rf_rs1_addr,
  output core_pkg::reg_idx_t  rf_rs2_addr,
  input  core_pkg::xlen_t     rf_rs1_data,
  input  core_pkg::xlen_t     rf_rs2_data,
  input  logic                mem_valid,
  input  core_pkg::reg_idx_t  mem_rd,
  input  logic                mem_wr_ena,
  input  logic                mem_is_load,
  input  core_pkg::xlen_t     mem_value,
  input  logic                wb_valid,
  input  core_pkg::reg_idx_t  wb_rd,
  input  logic                wb_wr_ena,
  input  core_pkg::xlen_t     wb_value,
  output logic                ex_valid,
  output core_pkg::mem_uop_t  ex_uop,
  output logic                redirect_valid,
  output core_pkg::xlen_t     redirect_pc
);

  import core_pkg::*;

  ex_uop_t uop;
  logic    hazard;
  xlen_t   rs1_value;
  xlen_t   rs2_value;
  xlen_t   op2;
  xlen_t   alu_result;
  logic    br_cond;
  logic    is_jump;
  xlen_t   jalr_sum;

  // issue register, holds its op for one cycle on load-use
  pipe_reg #(.payload_t(ex_uop_t)) u_issue (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_data      (in_uop),
    .next_allowin (1'b1),
    .ready_go     (!hazard),
    .allowin      (in_allowin),
    .out_valid    (ex_valid),
    .out_data     (uop)
  );

  assign rf_rs1_addr = uop.rs1;
  assign rf_rs2_addr = uop.rs2;

  forward_unit u_fwd (
    .rs1         (uop.rs1),
    .rs2         (uop.rs2),
    .use_rs1     (uop.use_rs1),
    .use_rs2     (uop.use_rs2),
    .rf_rs1_data (rf_rs1_data),
    .rf_rs2_data (rf_rs2_data),
    .mem_valid   (mem_valid),
    .mem_rd      (mem_rd),
    .mem_wr_ena  (mem_wr_ena),
    .mem_is_load (mem_is_load),
    .mem_value   (mem_value),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_wr_ena   (wb_wr_ena),
    .wb_value    (wb_value),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .hazard      (hazard)
  );

  assign op2 = uop.use_imm ? uop.imm : rs2_value;

  alu u_alu (
    .op1     (rs1_value),
    .op2     (op2),
    .alu_op  (uop.alu_op),
    .br_op   (uop.br_op),
    .result  (alu_result),
    .br_cond (br_cond)
  );

  assign is_jump  = (uop.br_op == br_jal) || (uop.br_op == br_jalr);
  assign jalr_sum = rs1_value + uop.imm;

  // only reported on the cycle the op actually leaves
  assign redirect_valid = ex_valid && br_cond;
  assign redirect_pc    = (uop.br_op == br_jalr) ? {jalr_sum[`CORE_XLEN-1:1], 1'b0}
                                                 : uop.pc + uop.imm;

  // link address replaces the ALU result for jumps
  assign ex_uop.result     = is_jump ? uop.pc + xlen_t'(4) : alu_result;
  assign ex_uop.store_data = rs2_value;
  assign ex_uop.rd         = uop.rd;
  assign ex_uop.mem_op     = uop.mem_op;
  assign ex_uop.wr_ena     = uop.wr_ena;

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
// memory stage with word data RAM
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module mem_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid,
  input  core_pkg::mem_uop_t uop,
  output core_pkg::xlen_t    fwd_value,
  output core_pkg::wb_uop_t  wb_uop,
  output core_pkg::xlen_t    load_data
);

  import core_pkg::*;

  localparam int AW = $clog2(`CORE_DMEM_WORDS);

  xlen_t         ram [`CORE_DMEM_WORDS];
  logic [AW-1:0] word_addr;
  logic          do_load;
  logic          do_store;
  xlen_t         rd_data_q;

  // byte offset dropped, upper bits wrap
  assign word_addr = uop.result[AW+1:2];
  assign do_load   = valid && (uop.mem_op == mem_load);
  assign do_store  = valid && (uop.mem_op == mem_store);

  always_ff @(posedge clk) begin
    if (do_store) begin
      ram[word_addr] <= uop.store_data;
    end
  end

  // read data lines up with the writeback register
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_q <= '0;
    end else if (do_load) begin
      rd_data_q <= ram[word_addr];
    end
  end

  assign load_data = rd_data_q;

  // a load here never forwards, hazard logic holds its consumer
  assign fwd_value = uop.result;

  assign wb_uop.value   = uop.result;
  assign wb_uop.rd      = uop.rd;
  assign wb_uop.wr_ena  = uop.wr_ena;
  assign wb_uop.is_load = (uop.mem_op == mem_load);

endmodule

`default_nettype wire

// File: hw/regfile.sv
// integer register file
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module regfile (
  input  logic               clk,
  input  logic               rst,
  input  core_pkg::reg_idx_t ra1,
  input  core_pkg::reg_idx_t ra2,
  output core_pkg::xlen_t    rd1,
  output core_pkg::xlen_t    rd2,
  input  logic               we,
  input  core_pkg::reg_idx_t wa,
  input  core_pkg::xlen_t    wd
);

  import core_pkg::*;

  xlen_t regs [`CORE_NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // x0 hardwired
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: hw/exec_pipe.sv
// execute pipeline top
`timescale 1ns/1ps
`default_nettype none

module exec_pipe (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  core_pkg::ex_uop_t  in_uop,
  output logic               in_allowin,
  output logic               retire_valid,
  output core_pkg::reg_idx_t retire_rd,
  output core_pkg::xlen_t    retire_data,
  output logic               redirect_valid,
  output core_pkg::xlen_t    redirect_pc
);

  import core_pkg::*;

  reg_idx_t rf_rs1_addr;
  reg_idx_t rf_rs2_addr;
  xlen_t    rf_rs1_data;
  xlen_t    rf_rs2_data;
  logic     ex_valid;
  mem_uop_t ex_uop;
  logic     mem_valid;
  mem_uop_t mem_uop;
  xlen_t    mem_fwd_value;
  wb_uop_t  mem_to_wb;
  xlen_t    load_data;
  logic     wb_valid;
  wb_uop_t  wb_uop;
  xlen_t    wb_value;

  ex_stage u_ex (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_uop         (in_uop),
    .in_allowin     (in_allowin),
    .rf_rs1_addr    (rf_rs1_addr),
    .rf_rs2_addr    (rf_rs2_addr),
    .rf_rs1_data    (rf_rs1_data),
    .rf_rs2_data    (rf_rs2_data),
    .mem_valid      (mem_valid),
    .mem_rd         (mem_uop.rd),
    .mem_wr_ena     (mem_uop.wr_ena),
    .mem_is_load    (mem_uop.mem_op == mem_load),
    .mem_value      (mem_fwd_value),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_uop.rd),
    .wb_wr_ena      (wb_uop.wr_ena),
    .wb_value       (wb_value),
    .ex_valid       (ex_valid),
    .ex_uop         (ex_uop),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  // memory and writeback never stall
  pipe_reg #(.payload_t(mem_uop_t)) u_ex_mem (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (ex_valid),
    .in_data      (ex_uop),
    .next_allowin (1'b1),
    .ready_go     (1'b1),
    .allowin      (),
    .out_valid    (mem_valid),
    .out_data     (mem_uop)
  );

  mem_stage u_mem (
    .clk       (clk),
    .rst       (rst),
    .valid     (mem_valid),
    .uop       (mem_uop),
    .fwd_value (mem_fwd_value),
    .wb_uop    (mem_to_wb),
    .load_data (load_data)
  );

  pipe_reg #(.payload_t(wb_uop_t)) u_mem_wb (
    .clk          (clk),
    .rst          (rst),
    .in_valid     (mem_valid),
    .in_data      (mem_to_wb),
    .next_allowin (1'b1),
    .ready_go     (1'b1),
    .allowin      (),
    .out_valid    (wb_valid),
    .out_data     (wb_uop)
  );

  // RAM read data arrives together with the load
  assign wb_value = wb_uop.is_load ? load_data : wb_uop.value;

  regfile u_rf (
    .clk (clk),
    .rst (rst),
    .ra1 (rf_rs1_addr),
    .ra2 (rf_rs2_addr),
    .rd1 (rf_rs1_data),
    .rd2 (rf_rs2_data),
    .we  (wb_valid && wb_uop.wr_ena),
    .wa  (wb_uop.rd),
    .wd  (wb_value)
  );

  assign retire_valid = wb_valid && wb_uop.wr_ena;
  assign retire_rd    = wb_uop.rd;
  assign retire_data  = wb_value;

endmodule

`default_nettype wire

// File: tests/exec_pipe_tb.sv
// execute pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_tb;

  import core_pkg::*;

  localparam int VEC_WORDS = 1024;
  localparam int NUM_GROUPS = 5;
  localparam int CYCLES_PER_OP = 20;

  logic     clk;
  logic     rst;
  logic     in_valid;
  ex_uop_t  in_uop;
  logic     in_allowin;
  logic     retire_valid;
  reg_idx_t retire_rd;
  xlen_t    retire_data;
  logic     redirect_valid;
  xlen_t    redirect_pc;

  // raw words from the vector file, then split into lists
  logic [31:0] vec [VEC_WORDS];
  ex_uop_t     ops [$];
  reg_idx_t    exp_rd [$];
  xlen_t       exp_data [$];
  int          exp_ret_grp [$];
  xlen_t       exp_pc [$];
  int          exp_redir_grp [$];

  string grp_name [NUM_GROUPS+1];
  int    grp_total [NUM_GROUPS+1] = '{default: 0};
  int    grp_seen [NUM_GROUPS+1] = '{default: 0};
  int    grp_errs [NUM_GROUPS+1] = '{default: 0};

  int errors = 0;
  int checks = 0;
  int load_errors = 0;
  int cycles = 0;
  int limit = 0;

  exec_pipe dut (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_uop         (in_uop),
    .in_allowin     (in_allowin),
    .retire_valid   (retire_valid),
    .retire_rd      (retire_rd),
    .retire_data    (retire_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  always #50 clk = !clk;

  task automatic count_expected(input int g);
    if (g < 1 || g > NUM_GROUPS) begin
      $display("vector file names group %0d, which does not exist", g);
      load_errors++;
    end else begin
      grp_total[g]++;
    end
  endtask

  task automatic load_vectors();
    int      p;
    ex_uop_t u;
    p = 0;
    $readmemh("tests/exec_pipe_vectors.txt", vec);
    while (p < VEC_WORDS - 13 && vec[p] != 32'd0) begin
      case (vec[p])
        32'd1: begin
          u.pc      = vec[p+1];
          u.rs1     = vec[p+2][4:0];
          u.rs2     = vec[p+3][4:0];
          u.rd      = vec[p+4][4:0];
          u.use_rs1 = vec[p+5][0];
          u.use_rs2 = vec[p+6][0];
          u.imm     = vec[p+7];
          u.use_imm = vec[p+8][0];
          u.alu_op  = alu_op_e'(vec[p+9][3:0]);
          u.br_op   = br_op_e'(vec[p+10][2:0]);
          u.mem_op  = mem_op_e'(vec[p+11][1:0]);
          u.wr_ena  = vec[p+12][0];
          ops.push_back(u);
          p = p + 13;
        end
        32'd2: begin
          count_expected(int'(vec[p+1]));
          exp_ret_grp.push_back(int'(vec[p+1]));
          exp_rd.push_back(vec[p+2][4:0]);
          exp_data.push_back(vec[p+3]);
          p = p + 4;
        end
        32'd3: begin
          count_expected(int'(vec[p+1]));
          exp_redir_grp.push_back(int'(vec[p+1]));
          exp_pc.push_back(vec[p+2]);
          p = p + 3;
        end
        default: begin
          $display("vector file has unknown record code %h at word %0d", vec[p], p);
          load_errors++;
          p = VEC_WORDS;
        end
      endcase
    end
  endtask

  // hold the op until the issue register takes it
  task automatic send_op(input ex_uop_t u);
    int gap;
    int stall;
    gap   = int'($urandom % 3);
    stall = 0;
    if (gap > 0) begin
      in_valid = 1'b0;
      repeat (gap) @(negedge clk);
    end
    in_valid = 1'b1;
    in_uop   = u;
    while (!in_allowin) begin
      stall++;
      @(negedge clk);
    end
    // a load-use stall blocks the input for a single cycle
    if (stall > 1) begin
      $display("in_allowin stayed low for %0d cycles, longer than one load-use stall",
               stall);
      errors++;
    end
    @(negedge clk);
  endtask

  task automatic note_group_event(input int g);
    grp_seen[g]++;
    if (grp_seen[g] == grp_total[g]) begin
      $display("group %s finished: %0d events, %0d wrong", grp_name[g], grp_total[g],
               grp_errs[g]);
    end
  endtask

  task automatic check_retire(input reg_idx_t rd, input xlen_t data);
    int       g;
    reg_idx_t want_rd;
    xlen_t    want_data;
    if (exp_rd.size() == 0) begin
      $display("unexpected retire of x%0d = %h after all expected retires", rd, data);
      errors++;
    end else begin
      g         = exp_ret_grp.pop_front();
      want_rd   = exp_rd.pop_front();
      want_data = exp_data.pop_front();
      checks++;
      if (rd !== want_rd || data !== want_data) begin
        $display("FAIL %s retire: expected x%0d = %h, got x%0d = %h", grp_name[g],
                 want_rd, want_data, rd, data);
        errors++;
        grp_errs[g]++;
      end
      note_group_event(g);
    end
  endtask

  task automatic check_redirect(input xlen_t pc);
    int    g;
    xlen_t want_pc;
    if (exp_pc.size() == 0) begin
      $display("unexpected redirect to %h after all expected redirects", pc);
      errors++;
    end else begin
      g       = exp_redir_grp.pop_front();
      want_pc = exp_pc.pop_front();
      checks++;
      if (pc !== want_pc) begin
        $display("FAIL %s redirect: expected pc %h, got pc %h", grp_name[g], want_pc, pc);
        errors++;
        grp_errs[g]++;
      end
      note_group_event(g);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (retire_valid) begin
        check_retire(retire_rd, retire_data);
      end
      if (redirect_valid) begin
        check_redirect(redirect_pc);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      if (cycles > limit) begin
        $display("timeout: the run did not end within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    in_valid = 1'b0;
    in_uop   = '0;
    void'($urandom(28));
    grp_name[0] = "none";
    grp_name[1] = "alu_ops";
    grp_name[2] = "fwd_chain";
    grp_name[3] = "load_store";
    grp_name[4] = "branches";
    grp_name[5] = "jumps";
    load_vectors();
    limit = ops.size() * CYCLES_PER_OP + 10;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (ops[i]) begin
      send_op(ops[i]);
    end
    in_valid = 1'b0;
    // last op retires within four cycles, five with a stall
    repeat (5) @(negedge clk);
    if (ops.size() == 0) begin
      $display("no ops were read from the vector file");
    end
    if (exp_rd.size() != 0) begin
      $display("%0d expected retires never happened", exp_rd.size());
    end
    if (exp_pc.size() != 0) begin
      $display("%0d expected redirects never happened", exp_pc.size());
    end
    $display("ops %0d, checks %0d, errors %0d", ops.size(), checks, errors + load_errors);
    if (errors == 0 && load_errors == 0 && exp_rd.size() == 0 && exp_pc.size() == 0 &&
        ops.size() != 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/exec_pipe_vectors.txt
// op:       1 pc rs1 rs2 rd use_rs1 use_rs2 imm use_imm alu_op br_op mem_op wr_ena
// retire:   2 group rd value        redirect: 3 group target        end: 0
1 100 00 00 01 0 0 00000010 1 0 0 0 1  2 1 01 00000010
1 104 00 00 02 0 0 fffffffd 1 0 0 0 1  2 1 02 fffffffd
1 108 01 02 03 1 1 00000000 0 0 0 0 1  2 1 03 0000000d
1 10c 01 02 04 1 1 00000000 0 1 0 0 1  2 1 04 00000013
1 110 01 00 05 1 0 000000ff 1 4 0 0 1  2 1 05 000000ef
1 114 02 00 06 1 0 00000001 1 7 0 0 1  2 1 06 fffffffe
1 118 02 00 07 1 0 0000001c 1 6 0 0 1  2 1 07 0000000f
1 11c 02 01 08 1 1 00000000 0 8 0 0 1  2 1 08 00000001
1 120 02 01 09 1 1 00000000 0 9 0 0 1  2 1 09 00000000
1 124 01 00 0a 1 0 00000004 1 5 0 0 1  2 1 0a 00000100
1 128 02 05 0b 1 1 00000000 0 2 0 0 1  2 1 0b 000000ed
1 12c 01 07 0c 1 1 00000000 0 3 0 0 1  2 1 0c 0000001f
1 200 00 00 0d 0 0 00000007 1 0 0 0 1  2 2 0d 00000007
1 204 0d 0d 0e 1 1 00000000 0 0 0 0 1  2 2 0e 0000000e
1 208 0e 0d 0f 1 1 00000000 0 0 0 0 1  2 2 0f 00000015
1 20c 0f 0e 10 1 1 00000000 0 1 0 0 1  2 2 10 00000007
1 300 00 00 11 0 0 000005a5 1 0 0 0 1  2 3 11 000005a5
1 304 00 11 00 1 1 00000020 1 0 0 2 0
1 308 00 00 12 1 0 00000020 1 0 0 1 1  2 3 12 000005a5
1 30c 12 00 13 1 0 00000001 1 0 0 0 1  2 3 13 000005a6
1 310 0d 13 00 1 1 00000041 1 0 0 2 0
1 314 00 00 14 1 0 00000048 1 0 0 1 1  2 3 14 000005a6
1 318 14 13 15 1 1 00000000 0 0 0 0 1  2 3 15 00000b4c
1 400 00 00 16 0 0 00000005 1 0 0 0 1  2 4 16 00000005
1 404 00 00 17 0 0 fffffffe 1 0 0 0 1  2 4 17 fffffffe
1 408 16 16 00 1 1 00000010 0 0 1 0 0  3 4 00000418
1 418 16 17 00 1 1 00000008 0 0 2 0 0  3 4 00000420
1 420 17 16 00 1 1 fffffff0 0 0 3 0 0  3 4 00000410
1 410 16 17 00 1 1 00000100 0 0 4 0 0  3 4 00000510
1 510 16 17 00 1 1 00000040 0 0 1 0 0
1 514 16 17 00 1 1 00000040 0 0 3 0 0
1 518 17 16 00 1 1 00000040 0 0 4 0 0
1 600 00 00 18 0 0 00000100 1 0 5 0 1  3 5 00000700  2 5 18 00000604
1 700 00 00 19 0 0 00001235 1 0 0 0 1  2 5 19 00001235
1 704 19 00 1a 1 0 00000002 1 0 6 0 1  3 5 00001236  2 5 1a 00000708
1 1236 00 00 00 0 0 00000005 1 0 0 0 1  2 5 00 00000005
1 123a 00 00 1b 1 1 00000000 0 0 0 0 1  2 5 1b 00000000
0

// File: vlog.f
+incdir+hw
hw/core_pkg.sv
hw/pipe_reg.sv
hw/forward_unit.sv
hw/alu.sv
hw/ex_stage.sv
hw/mem_stage.sv
hw/regfile.sv
hw/exec_pipe.sv
tests/exec_pipe_tb.sv

// File: Makefile
TOP = exec_pipe_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
